//--- axi_master/axi_read_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_fsm import lsu_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         start,
	input  access_plan_t plan,
	input  rd_rsp_t      rd_rsp,
	output rd_req_t      rd_req,
	output logic         beat_done,
	output logic         second,
	output logic         done
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA,
		RD_GAP
	} rd_state_e;

	rd_state_e state;
	rd_state_e state_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RD_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// --------------------------------------------------
	// next state
	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE: if (start) state_next = RD_ADDR;
			RD_ADDR: if (rd_rsp.arready) state_next = RD_DATA;
			RD_DATA: begin
				if (rd_rsp.rvalid) begin
					state_next = (plan.need_second && !second) ? RD_GAP : RD_IDLE;
				end
			end
			RD_GAP: state_next = RD_ADDR;
			default: state_next = RD_IDLE;
		endcase
	end

	// set for the second beat, dropped back in idle
	always_ff @(posedge clock) begin
		if (reset) begin
			second <= 1'b0;
		end else if (state_next == RD_GAP) begin
			second <= 1'b1;
		end else if (state == RD_IDLE) begin
			second <= 1'b0;
		end
	end

	// --------------------------------------------------
	// bus outputs straight from state
	always_comb begin
		rd_req.arvalid = (state == RD_ADDR);
		rd_req.araddr  = second ? plan.second_addr : plan.first_addr;
		rd_req.rready  = (state == RD_DATA);
	end

	assign beat_done = (state == RD_DATA) && rd_rsp.rvalid;
	assign done      = beat_done && (second || !plan.need_second);

endmodule

`default_nettype wire

//--- axi_master/axi_write_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_fsm import lsu_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         start,
	input  access_plan_t plan,
	input  wr_rsp_t      wr_rsp,
	output wr_req_t      wr_req,
	output logic         done
);

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_GAP
	} wr_state_e;

	wr_state_e state;
	wr_state_e state_next;
	logic      second;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WR_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// --------------------------------------------------
	// next state
	// address, then data, then response for each beat
	always_comb begin
		state_next = state;
		case (state)
			WR_IDLE: if (start) state_next = WR_ADDR;
			WR_ADDR: if (wr_rsp.awready) state_next = WR_DATA;
			WR_DATA: if (wr_rsp.wready) state_next = WR_RESP;
			WR_RESP: begin
				if (wr_rsp.bvalid) begin
					state_next = (plan.need_second && !second) ? WR_GAP : WR_IDLE;
				end
			end
			WR_GAP: state_next = WR_ADDR;
			default: state_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			second <= 1'b0;
		end else if (state_next == WR_GAP) begin
			second <= 1'b1;
		end else if (state == WR_IDLE) begin
			second <= 1'b0;
		end
	end

	// --------------------------------------------------
	// bus outputs
	// same rotated data for both beats, strobe picks the lanes
	always_comb begin
		wr_req.awvalid = (state == WR_ADDR);
		wr_req.awaddr  = second ? plan.second_addr : plan.first_addr;
		wr_req.wvalid  = (state == WR_DATA);
		wr_req.wdata   = plan.wdata;
		wr_req.wstrb   = second ? plan.second_strb : plan.first_strb;
		wr_req.bready  = (state == WR_RESP);
	end

	assign done = (state == WR_RESP) && wr_rsp.bvalid
		&& (second || !plan.need_second);

endmodule

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// --------------------------------------------------
	// widths
	localparam int XLEN   = 32;
	localparam int BUS_W  = 64;
	localparam int STRB_W = 8;
	localparam int REG_AW = 5;

	// load/store operations
	typedef enum logic [2:0] {
		OP_LB  = 3'd0,
		OP_LH  = 3'd1,
		OP_LW  = 3'd2,
		OP_LBU = 3'd3,
		OP_LHU = 3'd4,
		OP_SB  = 3'd5,
		OP_SH  = 3'd6,
		OP_SW  = 3'd7
	} mem_op_e;

	// one memory instruction from decode
	typedef struct packed {
		mem_op_e           op;
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
		logic [REG_AW-1:0] rd;
	} lsu_req_t;

	// lane planner result, one or two beats
	typedef struct packed {
		logic              need_second;
		logic [XLEN-1:0]   first_addr;
		logic [XLEN-1:0]   second_addr;
		logic [STRB_W-1:0] first_strb;
		logic [STRB_W-1:0] second_strb;
		logic [BUS_W-1:0]  wdata;
	} access_plan_t;

	// --------------------------------------------------
	// memory bus channels
	typedef struct packed {
		logic            arvalid;
		logic [XLEN-1:0] araddr;
		logic            rready;
	} rd_req_t;

	typedef struct packed {
		logic             arready;
		logic             rvalid;
		logic [BUS_W-1:0] rdata;
	} rd_rsp_t;

	typedef struct packed {
		logic              awvalid;
		logic [XLEN-1:0]   awaddr;
		logic              wvalid;
		logic [BUS_W-1:0]  wdata;
		logic [STRB_W-1:0] wstrb;
		logic              bready;
	} wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
	} wr_rsp_t;

	// register file write port
	typedef struct packed {
		logic              wen;
		logic [REG_AW-1:0] waddr;
		logic [XLEN-1:0]   wdata;
	} rf_write_t;

	function automatic logic is_load(mem_op_e op);
		return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	endfunction

	function automatic logic is_store(mem_op_e op);
		return op inside {OP_SB, OP_SH, OP_SW};
	endfunction

endpackage

`default_nettype wire

//--- flist.f
common/lsu_pkg.sv
hdl/lsu_req_stage.sv
hdl/lsu_lane_plan.sv
axi_master/axi_read_fsm.sv
axi_master/axi_write_fsm.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
sim/lsu_asserts.sv
sim/mem_model.sv
sim/tb_lsu.sv

//--- hdl/lsu_lane_plan.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_lane_plan import lsu_pkg::*; (
	input  lsu_req_t     cur,
	output access_plan_t plan
);

	localparam int WORD_BYTES = XLEN / 8;

	logic [2:0]          off;
	logic                is_word;
	logic                is_half;
	logic [STRB_W-1:0]   size_mask;
	logic [2*STRB_W-1:0] span;
	logic [STRB_W-1:0]   lanes;
	logic [STRB_W-1:0]   word_lanes;
	logic                need_second;

	assign off     = cur.addr[2:0];
	assign is_word = cur.op inside {OP_LW, OP_SW};
	assign is_half = cur.op inside {OP_LH, OP_LHU, OP_SH};

	// --------------------------------------------------
	// access size as a lane mask at offset 0
	always_comb begin
		if (is_word) begin
			size_mask = 8'b0000_1111;
		end else if (is_half) begin
			size_mask = 8'b0000_0011;
		end else begin
			size_mask = 8'b0000_0001;
		end
	end

	// shift by the offset, upper half wraps back to lane 0
	assign span  = {{STRB_W{1'b0}}, size_mask} << off;
	assign lanes = span[STRB_W-1:0] | span[2*STRB_W-1:STRB_W];

	// the aligned 4-byte word that holds addr
	assign word_lanes = off[2] ? 8'b1111_0000 : 8'b0000_1111;

	// crossing a 4-byte boundary
	assign need_second = (is_word && off[1:0] != 2'b00)
		|| (is_half && off[1:0] == 2'b11);

	// --------------------------------------------------
	// beat addresses, strobes and store data
	always_comb begin
		logic [2:0] lane;

		plan             = '0;
		plan.need_second = need_second;
		plan.first_addr  = cur.addr;
		plan.second_addr = {cur.addr[XLEN-1:2] + (XLEN-2)'(1), 2'b00};
		plan.first_strb  = lanes & word_lanes;
		plan.second_strb = need_second ? (lanes & ~word_lanes) : '0;

		// byte k goes to lane (addr + k) mod 8
		for (int k = 0; k < WORD_BYTES; k++) begin
			lane = off + 3'(k);
			plan.wdata[lane*8 +: 8] = cur.wdata[k*8 +: 8];
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  mem_op_e          op,
	input  access_plan_t     plan,
	input  logic [BUS_W-1:0] rdata,
	input  logic             beat_done,
	input  logic             second,
	output logic [XLEN-1:0]  load_data
);

	localparam int WORD_BYTES = XLEN / 8;

	logic [BUS_W-1:0] first_q;
	logic [BUS_W-1:0] first_beat;
	logic [7:0]       bytes [WORD_BYTES];
	logic [XLEN-1:0]  word;

	// first half of a split read
	always_ff @(posedge clock) begin
		if (reset) begin
			first_q <= '0;
		end else if (beat_done && !second && plan.need_second) begin
			first_q <= rdata;
		end
	end

	assign first_beat = plan.need_second ? first_q : rdata;

	// --------------------------------------------------
	// byte k comes from lane k or lane k+4 of either beat
	always_comb begin
		for (int k = 0; k < WORD_BYTES; k++) begin
			bytes[k] = ({8{plan.first_strb[k]}} & first_beat[k*8 +: 8])
				| ({8{plan.first_strb[k+4]}} & first_beat[(k+4)*8 +: 8])
				| ({8{plan.second_strb[k]}} & rdata[k*8 +: 8])
				| ({8{plan.second_strb[k+4]}} & rdata[(k+4)*8 +: 8]);
		end
	end

	// undo the address rotation
	always_comb begin
		logic [1:0] idx;

		for (int j = 0; j < WORD_BYTES; j++) begin
			idx = 2'(j) + plan.first_addr[1:0];
			word[j*8 +: 8] = bytes[idx];
		end
	end

	// --------------------------------------------------
	// sign or zero extension
	always_comb begin
		case (op)
			OP_LB:   load_data = {{24{word[7]}}, word[7:0]};
			OP_LBU:  load_data = {24'b0, word[7:0]};
			OP_LH:   load_data = {{16{word[15]}}, word[15:0]};
			OP_LHU:  load_data = {16'b0, word[15:0]};
			default: load_data = word;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/lsu_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_stage import lsu_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            in_valid,
	input  lsu_req_t        req,
	output logic            allowin,
	output lsu_req_t        cur,
	output logic            busy,
	input  logic            mem_done,
	input  logic [XLEN-1:0] load_data,
	output rf_write_t       rf_write,
	output logic            done
);

	logic accept;

	// --------------------------------------------------
	// handshake with decode
	// a finishing instruction frees the stage in the same cycle
	assign done    = busy && mem_done;
	assign allowin = !busy || done;
	assign accept  = in_valid && allowin;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// held stable until done
	always_ff @(posedge clock) begin
		if (accept) begin
			cur <= req;
		end
	end

	// --------------------------------------------------
	// register file write on load completion
	always_comb begin
		rf_write.wen   = done && is_load(cur.op);
		rf_write.waddr = cur.rd;
		rf_write.wdata = load_data;
	end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      in_valid,
	input  lsu_req_t  req,
	output logic      allowin,
	input  rd_rsp_t   rd_rsp,
	output rd_req_t   rd_req,
	input  wr_rsp_t   wr_rsp,
	output wr_req_t   wr_req,
	output rf_write_t rf_write,
	output logic      done
);

	lsu_req_t        cur;
	logic            busy;
	access_plan_t    plan;
	logic            rd_done;
	logic            wr_done;
	logic            beat_done;
	logic            second;
	logic [XLEN-1:0] load_data;

	// --------------------------------------------------
	// instruction holding register
	lsu_req_stage u_req_stage (
		.clock    (clock),
		.reset    (reset),
		.in_valid (in_valid),
		.req      (req),
		.allowin  (allowin),
		.cur      (cur),
		.busy     (busy),
		.mem_done (rd_done | wr_done),
		.load_data(load_data),
		.rf_write (rf_write),
		.done     (done)
	);

	lsu_lane_plan u_lane_plan (
		.cur (cur),
		.plan(plan)
	);

	// --------------------------------------------------
	// bus masters, only one of them runs per instruction
	axi_read_fsm u_read_fsm (
		.clock    (clock),
		.reset    (reset),
		.start    (busy && is_load(cur.op)),
		.plan     (plan),
		.rd_rsp   (rd_rsp),
		.rd_req   (rd_req),
		.beat_done(beat_done),
		.second   (second),
		.done     (rd_done)
	);

	axi_write_fsm u_write_fsm (
		.clock (clock),
		.reset (reset),
		.start (busy && is_store(cur.op)),
		.plan  (plan),
		.wr_rsp(wr_rsp),
		.wr_req(wr_req),
		.done  (wr_done)
	);

	lsu_load_align u_load_align (
		.clock    (clock),
		.reset    (reset),
		.op       (cur.op),
		.plan     (plan),
		.rdata    (rd_rsp.rdata),
		.beat_done(beat_done),
		.second   (second),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

//--- sim/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts import lsu_pkg::*; (
	input logic      clock,
	input logic      reset,
	input rd_req_t   rd_req,
	input rd_rsp_t   rd_rsp,
	input wr_req_t   wr_req,
	input wr_rsp_t   wr_rsp,
	input rf_write_t rf_write,
	input logic      done
);

	// number of failed assertions so far
	int failures = 0;

	// --------------------------------------------------
	// address channels hold until accepted
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		rd_req.arvalid && !rd_rsp.arready |=> rd_req.arvalid && $stable(rd_req.araddr))
		else begin
			$error("arvalid dropped or araddr changed before arready");
			failures++;
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		wr_req.awvalid && !wr_rsp.awready |=> wr_req.awvalid && $stable(wr_req.awaddr))
		else begin
			$error("awvalid dropped or awaddr changed before awready");
			failures++;
		end

	// write data only after its address
	w_after_aw: assert property (@(posedge clock) disable iff (reset)
		$rose(wr_req.wvalid) |-> $past(wr_req.awvalid && wr_rsp.awready))
		else begin
			$error("wvalid rose without a preceding address handshake");
			failures++;
		end

	wen_in_done: assert property (@(posedge clock) disable iff (reset)
		rf_write.wen |-> done)
		else begin
			$error("register write outside a done cycle");
			failures++;
		end

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import lsu_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  rd_req_t rd_req,
	output rd_rsp_t rd_rsp,
	input  wr_req_t wr_req,
	output wr_rsp_t wr_rsp
);

	localparam int MEM_BYTES = 256;

	logic [7:0]  mem [MEM_BYTES];
	logic [31:0] seed = 32'd50;
	logic [31:0] rd_addr;
	logic [31:0] wr_addr;
	logic        ar_hs = 1'b0;
	logic        r_hs = 1'b0;
	logic        aw_hs = 1'b0;
	logic        w_hs = 1'b0;
	logic        b_hs = 1'b0;
	logic        r_pend;
	logic        b_pend;
	logic [1:0]  r_wait;
	logic [1:0]  b_wait;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// lane i holds byte (addr rounded down to 8) + i
	function automatic logic [BUS_W-1:0] read_beat(logic [31:0] addr);
		logic [BUS_W-1:0] beat;
		logic [7:0]       a;

		for (int i = 0; i < 8; i++) begin
			a = {addr[7:3], 3'b000} + 8'(i);
			beat[i*8 +: 8] = mem[a];
		end
		return beat;
	endfunction

	initial begin
		rd_rsp = '0;
		wr_rsp = '0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = 8'(i * 29 + 7);
		end
	end

	// --------------------------------------------------
	// handshakes complete on the rising edge
	always @(posedge clock) begin
		ar_hs = rd_req.arvalid && rd_rsp.arready;
		r_hs  = rd_req.rready && rd_rsp.rvalid;
		aw_hs = wr_req.awvalid && wr_rsp.awready;
		w_hs  = wr_req.wvalid && wr_rsp.wready;
		b_hs  = wr_req.bready && wr_rsp.bvalid;
		if (ar_hs) begin
			rd_addr = rd_req.araddr;
		end
		if (aw_hs) begin
			wr_addr = wr_req.awaddr;
		end
		if (w_hs) begin
			for (int i = 0; i < 8; i++) begin
				if (wr_req.wstrb[i]) begin
					mem[{wr_addr[7:3], 3'b000} + 8'(i)] = wr_req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// --------------------------------------------------
	// responses change on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			rd_rsp = '0;
			wr_rsp = '0;
			r_pend = 1'b0;
			b_pend = 1'b0;
			r_wait = '0;
			b_wait = '0;
		end else begin
			seed = lcg_next(seed);
			// ready roughly three cycles in four
			rd_rsp.arready = seed[16] | seed[17];
			wr_rsp.awready = seed[18] | seed[19];
			wr_rsp.wready  = seed[20] | seed[21];
			if (r_hs) begin
				rd_rsp.rvalid = 1'b0;
			end
			if (ar_hs) begin
				r_pend = 1'b1;
				r_wait = seed[23:22];
			end
			if (r_pend && r_wait == 0) begin
				rd_rsp.rvalid = 1'b1;
				rd_rsp.rdata  = read_beat(rd_addr);
				r_pend        = 1'b0;
			end else if (r_pend) begin
				r_wait = r_wait - 2'd1;
			end
			if (b_hs) begin
				wr_rsp.bvalid = 1'b0;
			end
			if (w_hs) begin
				b_pend = 1'b1;
				b_wait = seed[25:24];
			end
			if (b_pend && b_wait == 0) begin
				wr_rsp.bvalid = 1'b1;
				b_pend        = 1'b0;
			end else if (b_pend) begin
				b_wait = b_wait - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

	localparam int LIMIT = 200;

	logic        clock = 1'b0;
	logic        reset;
	logic        in_valid;
	lsu_req_t    req;
	logic        allowin;
	rd_rsp_t     rd_rsp;
	rd_req_t     rd_req;
	wr_rsp_t     wr_rsp;
	wr_req_t     wr_req;
	rf_write_t   rf_write;
	logic        done;
	logic [7:0]  ref_mem [256];
	logic [31:0] rnd = 32'd50;

	lsu_top dut0 (
		.clock   (clock),
		.reset   (reset),
		.in_valid(in_valid),
		.req     (req),
		.allowin (allowin),
		.rd_rsp  (rd_rsp),
		.rd_req  (rd_req),
		.wr_rsp  (wr_rsp),
		.wr_req  (wr_req),
		.rf_write(rf_write),
		.done    (done)
	);

	mem_model mem0 (
		.clock (clock),
		.reset (reset),
		.rd_req(rd_req),
		.rd_rsp(rd_rsp),
		.wr_req(wr_req),
		.wr_rsp(wr_rsp)
	);

	bind lsu_top lsu_asserts asserts0 (
		.clock   (clock),
		.reset   (reset),
		.rd_req  (rd_req),
		.rd_rsp  (rd_rsp),
		.wr_req  (wr_req),
		.wr_rsp  (wr_rsp),
		.rf_write(rf_write),
		.done    (done)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] lcg(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort(string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			abort($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// a bound assertion failure ends the run
	always @(negedge clock) begin
		if (dut0.asserts0.failures != 0) begin
			abort("a bus protocol or register port assertion failed");
		end
	end

	// --------------------------------------------------
	// reference model, little endian bytes
	function automatic logic [31:0] expect_load(mem_op_e op, logic [31:0] addr);
		logic [7:0] b [4];

		for (int k = 0; k < 4; k++) begin
			b[k] = ref_mem[addr[7:0] + 8'(k)];
		end
		case (op)
			OP_LB:   return {{24{b[0][7]}}, b[0]};
			OP_LBU:  return {24'b0, b[0]};
			OP_LH:   return {{16{b[1][7]}}, b[1], b[0]};
			OP_LHU:  return {16'b0, b[1], b[0]};
			OP_LW:   return {b[3], b[2], b[1], b[0]};
			default: return 32'b0;
		endcase
	endfunction

	task automatic store_ref(mem_op_e op, logic [31:0] addr, logic [31:0] data);
		int n;

		n = (op == OP_SW) ? 4 : (op == OP_SH) ? 2 : 1;
		for (int k = 0; k < n; k++) begin
			ref_mem[addr[7:0] + 8'(k)] = data[k*8 +: 8];
		end
	endtask

	// one instruction, waits for done and checks the register port
	task automatic run_op(string name, mem_op_e op, logic [31:0] addr, logic [31:0] data,
			logic [4:0] rd);
		int          waited;
		logic        store;
		logic [31:0] expected;

		store    = op inside {OP_SB, OP_SH, OP_SW};
		expected = expect_load(op, addr);
		@(negedge clock);
		in_valid  = 1'b1;
		req.op    = op;
		req.addr  = addr;
		req.wdata = data;
		req.rd    = rd;
		waited    = 0;
		@(posedge clock);
		while (!allowin) begin
			waited++;
			if (waited > LIMIT) abort({name, ": request was never accepted"});
			@(posedge clock);
		end
		@(negedge clock);
		in_valid = 1'b0;
		waited   = 0;
		@(posedge clock);
		while (!done) begin
			check({name, " allowin while busy"}, 32'd0, allowin);
			check({name, " wen before done"}, 32'd0, rf_write.wen);
			waited++;
			if (waited > LIMIT) abort({name, ": instruction never completed"});
			@(posedge clock);
		end
		if (store) begin
			check({name, " store wen"}, 32'd0, rf_write.wen);
			store_ref(op, addr, data);
		end else begin
			check({name, " load wen"}, 32'd1, rf_write.wen);
			check({name, " load rd"}, 32'(rd), 32'(rf_write.waddr));
			check({name, " load data"}, expected, rf_write.wdata);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	task automatic reset_values();
		@(posedge clock);
		check("reset allowin", 32'd1, allowin);
		check("reset arvalid", 32'd0, rd_req.arvalid);
		check("reset rready", 32'd0, rd_req.rready);
		check("reset awvalid", 32'd0, wr_req.awvalid);
		check("reset wvalid", 32'd0, wr_req.wvalid);
		check("reset bready", 32'd0, wr_req.bready);
		check("reset wen", 32'd0, rf_write.wen);
		check("reset done", 32'd0, done);
	endtask

	task automatic aligned_store_load();
		run_op("sw aligned", OP_SW, 32'h40, 32'hdead_beef, 5'd0);
		run_op("lw aligned", OP_LW, 32'h40, 32'h0, 5'd7);
	endtask

	task automatic narrow_loads();
		for (int off = 0; off < 8; off++) begin
			run_op($sformatf("lb off %0d", off), OP_LB, 32'h80 + off, 32'h0, 5'd1);
			run_op($sformatf("lbu off %0d", off), OP_LBU, 32'h80 + off, 32'h0, 5'd2);
			run_op($sformatf("lh off %0d", off), OP_LH, 32'h80 + off, 32'h0, 5'd3);
			run_op($sformatf("lhu off %0d", off), OP_LHU, 32'h80 + off, 32'h0, 5'd4);
		end
	endtask

	task automatic unaligned_store();
		run_op("sw off 5", OP_SW, 32'h95, 32'h1234_5678, 5'd0);
		check("sw off 5 low byte", 32'h78, 32'(mem0.mem[8'h95]));
		check("sw off 5 high byte", 32'h12, 32'(mem0.mem[8'h98]));
		for (int a = 8'h90; a < 8'ha0; a++) begin
			check($sformatf("sw off 5 byte %h", a), 32'(ref_mem[a]), 32'(mem0.mem[a]));
		end
		run_op("lw off 5", OP_LW, 32'h95, 32'h0, 5'd9);
	endtask

	task automatic random_mix();
		mem_op_e     op;
		logic [31:0] addr;

		for (int i = 0; i < 40; i++) begin
			rnd  = lcg(rnd);
			op   = mem_op_e'(rnd[18:16]);
			addr = {24'b0, rnd[31:24]};
			rnd  = lcg(rnd);
			run_op($sformatf("random %0d", i), op, addr, rnd, 5'(i % 31 + 1));
		end
		for (int a = 0; a < 256; a++) begin
			check($sformatf("random final byte %h", a), 32'(ref_mem[a]), 32'(mem0.mem[a]));
		end
	endtask

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		req      = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int a = 0; a < 256; a++) begin
			ref_mem[a] = mem0.mem[a];
		end
		reset_values();
		aligned_store_load();
		narrow_loads();
		unaligned_store();
		random_mix();
		@(posedge clock);
		if (dut0.asserts0.failures == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort("a bus protocol or register port assertion failed");
		end
	end

endmodule

`default_nettype wire
